// ==== build.f ====
+incdir+rtl
rtl/vga_pkg.sv
rtl/sram_1r1w.sv
rtl/vga_sequencer.sv
rtl/vga_frame_fetch.sv
rtl/vga_pixel_fifo.sv
rtl/vga_controller.sv
dv/vga_controller_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal
TOP = vga_controller_tb
FILELIST = build.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/vga_controller_tb.sv ====
`timescale 1ns/1ns

`include "vga_macros.svh"

module vga_controller_tb;

	import vga_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int HS_WIDTH = 2;
	// Clocks per frame for the two programs at two clocks per pixel period
	localparam int FRAME1_CLOCKS = 2 * (3 * (6 + 3) + 6 + 5);
	localparam int FRAME2_CLOCKS = 2 * (5 * (10 + 3) + 10 + 5);
	localparam int WATCHDOG_NS = (7 * FRAME1_CLOCKS + 3 * FRAME2_CLOCKS + 150) * 4 * CLK_PERIOD;

	logic clk = 1'b0;
	logic reset;
	logic sequencer_en;
	logic prog_write_en;
	logic [31:0] prog_data;
	logic [15:0] fb_base;
	logic mem_read_en;
	logic [15:0] mem_read_addr;
	logic [31:0] mem_read_data;
	logic vga_hs;
	logic vga_vs;
	logic vga_de;
	pixel_t vga_color;
	logic pixel_en;

	integer seed = 32'h87fb_452b;
	logic [31:0] salt;
	logic [31:0] prog[$];
	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int exp_lines;
	int exp_visible;

	// Monitor state
	logic en_prev;
	logic hs_prev;
	logic vs_prev;
	int hs_width;
	int vs_width;
	int hs_count;
	int pix_index;
	int reads;
	int consumed;
	int frames_seen = 0;
	logic backpressure_seen;
	logic [15:0] frame_base;

	vga_controller i_vga_controller (
		.clk(clk),
		.reset(reset),
		.sequencer_en(sequencer_en),
		.prog_write_en(prog_write_en),
		.prog_data(prog_data),
		.fb_base(fb_base),
		.mem_read_en(mem_read_en),
		.mem_read_addr(mem_read_addr),
		.mem_read_data(mem_read_data),
		.vga_hs(vga_hs),
		.vga_vs(vga_vs),
		.vga_de(vga_de),
		.vga_color(vga_color),
		.pixel_en(pixel_en)
	);

	always #(CLK_PERIOD / 2) clk = !clk;

	// Frame-buffer word for an address mixed with the run's salt
	function automatic logic [31:0] mem_word(input logic [15:0] addr);
		return {addr, ~addr} ^ (32'(addr) * 32'h9e37_79b9) ^ salt;
	endfunction

	// Memory model answers one clock after the request
	always @(posedge clk)
	begin
		if (mem_read_en)
			mem_read_data <= mem_word(mem_read_addr);
	end

	task automatic report_fail(input string msg);
		$display("FAIL %0t: %s", $time, msg);
		errors++;
	endtask

	// Pack one microinstruction into a program word
	function automatic logic [31:0] uop_word(input bit is_loop, input bit sel, input int imm,
		input bit vs, input bit hs, input bit done, input bit vis);
		return {13'b0, is_loop, sel, imm[12:0], vs, hs, done, vis};
	endfunction

	// Lines of a 2-pixel hsync, the visible pixels and one blank pixel
	// Then one vsync line of the same length and a jump back to slot 0
	task automatic build_program(input int lines, input int visible);
		prog.delete();
		prog.push_back(uop_word(0, 1, lines, 0, 0, 0, 0));
		prog.push_back(uop_word(0, 0, 0, 0, 1, 0, 0));
		prog.push_back(uop_word(0, 0, visible, 0, 1, 0, 0));
		prog.push_back(uop_word(1, 0, 3, 0, 0, 0, 1));
		prog.push_back(uop_word(1, 1, 1, 0, 0, 0, 0));
		prog.push_back(uop_word(0, 0, visible + 2, 1, 0, 0, 0));
		prog.push_back(uop_word(1, 0, 6, 1, 0, 0, 0));
		prog.push_back(uop_word(0, 0, 0, 0, 0, 1, 0));
		exp_lines = lines;
		exp_visible = visible;
	endtask

	task automatic load_program();
		foreach (prog[i])
		begin
			@(posedge clk);
			prog_write_en <= 1'b1;
			prog_data <= prog[i];
		end
		@(posedge clk);
		prog_write_en <= 1'b0;
		prog_data <= '0;
	endtask

	// Frames end on the falling edge of vsync
	task automatic wait_frames(input int n);
		int target;
		target = frames_seen + n;
		while (frames_seen < target)
			@(negedge clk);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		if (errors == errors_before)
		begin
			$display("PASS: %s", name);
			tests_passed++;
		end
		else
		begin
			$display("FAIL %0t: %s saw %0d errors", $time, name, errors - errors_before);
			tests_failed++;
		end
	endtask

	// Continuous checks of sync widths, pixel order, read addresses and credits
	always @(negedge clk)
	begin
		pixel_t expected;
		if (reset || !sequencer_en)
			en_prev = 1'b0;
		else
		begin
			if (!en_prev)
			begin
				// Frame starts right at enable
				hs_prev = 1'b0;
				vs_prev = 1'b0;
				hs_width = 0;
				vs_width = 0;
				hs_count = 0;
				pix_index = 0;
				reads = 0;
				consumed = 0;
				frame_base = fb_base;
			end
			en_prev = 1'b1;
			assert (reads - consumed <= `VGA_FIFO_DEPTH)
			else report_fail("reads ahead of consumed pixels by more than the FIFO depth");
			if (reads - consumed == `VGA_FIFO_DEPTH)
			begin
				backpressure_seen = 1'b1;
				assert (!mem_read_en) else report_fail("read issued with no credits left");
			end
			if (mem_read_en)
			begin
				// Reads walk up from the frame base one word at a time
				assert (mem_read_addr == frame_base + 16'(reads))
				else report_fail($sformatf("read address %h, expected %h", mem_read_addr,
					frame_base + 16'(reads)));
				reads++;
			end
			if (vga_de && pixel_en)
				consumed++;
			// New colour is in place on the second clock of vga_de per pixel
			if (vga_de && !pixel_en)
			begin
				expected = pixel_t'(mem_word(frame_base + 16'(pix_index)));
				assert (vga_color == expected)
				else report_fail($sformatf("pixel %0d colour %h, expected %h",
					pix_index, vga_color, expected));
				pix_index++;
			end
			if (vga_hs && pixel_en)
				hs_width++;
			if (vga_vs && pixel_en)
				vs_width++;
			if (!vga_hs && hs_prev)
			begin
				assert (hs_width == HS_WIDTH)
				else report_fail($sformatf("hsync width %0d, expected %0d", hs_width, HS_WIDTH));
				hs_count++;
				hs_width = 0;
			end
			if (!vga_vs && vs_prev)
			begin
				assert (vs_width == exp_visible + 3)
				else report_fail($sformatf("vsync width %0d, expected %0d", vs_width,
					exp_visible + 3));
				assert (hs_count == exp_lines)
				else report_fail($sformatf("%0d hsync pulses, expected %0d", hs_count, exp_lines));
				assert (pix_index == exp_lines * exp_visible)
				else report_fail($sformatf("%0d pixels in frame, expected %0d", pix_index,
					exp_lines * exp_visible));
				vs_width = 0;
				hs_count = 0;
				pix_index = 0;
				reads = 0;
				consumed = 0;
				frame_base = fb_base;
				frames_seen++;
			end
			hs_prev = vga_hs;
			vs_prev = vga_vs;
		end
	end

	task automatic verify_reset_state();
		int errors_before;
		errors_before = errors;
		repeat (10) @(posedge clk);
		@(negedge clk);
		assert (!mem_read_en && !vga_hs && !vga_vs && !vga_de && !pixel_en && vga_color == '0)
		else report_fail("outputs not in reset state during reset");
		@(posedge clk);
		reset <= 1'b0;
		// Still disabled after reset so nothing moves
		repeat (6)
		begin
			@(negedge clk);
			assert (!mem_read_en && !vga_hs && !vga_vs && !vga_de && vga_color == '0)
			else report_fail("outputs active after reset while disabled");
		end
		finish_test("reset state", errors_before);
	endtask

	task automatic load_and_sync();
		int errors_before;
		errors_before = errors;
		build_program(3, 6);
		load_program();
		@(posedge clk);
		sequencer_en <= 1'b1;
		wait_frames(2);
		finish_test("program load and sync", errors_before);
	endtask

	task automatic pixel_order_across_bases();
		int errors_before;
		logic [15:0] bases[2] = '{16'h4a30, 16'hfffc};
		errors_before = errors;
		// Base changes inside vsync take effect at the next frame
		foreach (bases[i])
		begin
			@(negedge clk);
			while (!vga_vs)
				@(negedge clk);
			@(posedge clk);
			fb_base <= bases[i];
			wait_frames(1);
		end
		wait_frames(1);
		finish_test("pixel order", errors_before);
	endtask

	task automatic watch_credit_window();
		int errors_before;
		errors_before = errors;
		backpressure_seen = 1'b0;
		wait_frames(2);
		assert (backpressure_seen)
		else report_fail("FIFO never reached a full credit window");
		finish_test("credit flow", errors_before);
	endtask

	task automatic disable_and_reprogram();
		int errors_before;
		pixel_t held;
		errors_before = errors;
		@(posedge clk);
		sequencer_en <= 1'b0;
		@(negedge clk);
		@(negedge clk);
		held = vga_color;
		repeat (40)
		begin
			@(negedge clk);
			assert (!vga_hs && !vga_vs && !vga_de && vga_color == held)
			else report_fail("display outputs moved while disabled");
		end
		build_program(5, 10);
		load_program();
		@(posedge clk);
		sequencer_en <= 1'b1;
		wait_frames(2);
		finish_test("disable and reprogram", errors_before);
	endtask

	initial
	begin
		reset = 1'b1;
		sequencer_en = 1'b0;
		prog_write_en = 1'b0;
		prog_data = '0;
		fb_base = 16'h0100;
		mem_read_data = '0;
		salt = $random(seed);
		verify_reset_state();
		load_and_sync();
		pixel_order_across_bases();
		watch_credit_window();
		disable_and_reprogram();
		$display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// Run limit from the frame lengths of all tests
	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== rtl/vga_controller.sv ====
`timescale 1ns/1ns

`include "vga_macros.svh"

module vga_controller (
	input clk,
	input reset,
	input sequencer_en,
	input prog_write_en,
	input [`VGA_WORD_WIDTH-1:0] prog_data,
	input [`VGA_MEM_ADDR_WIDTH-1:0] fb_base,
	output logic mem_read_en,
	output logic [`VGA_MEM_ADDR_WIDTH-1:0] mem_read_addr,
	input [`VGA_WORD_WIDTH-1:0] mem_read_data,
	output logic vga_hs,
	output logic vga_vs,
	output logic vga_de,
	output vga_pkg::pixel_t vga_color,
	output logic pixel_en
);

	import vga_pkg::*;

	logic in_visible_region;
	logic start_dma;
	logic push;
	pixel_t push_data;
	logic flush;
	logic pop;
	pixel_t pop_data;
	logic fifo_empty;
	logic credit_return;
	logic pixel_due;

	// Timing generator, sync outputs leave undelayed
	vga_sequencer i_vga_sequencer (
		.clk(clk),
		.reset(reset),
		.sequencer_en(sequencer_en),
		.prog_write_en(prog_write_en),
		.prog_data(prog_data),
		.vga_hs(vga_hs),
		.vga_vs(vga_vs),
		.in_visible_region(in_visible_region),
		.start_dma(start_dma),
		.pixel_en(pixel_en)
	);

	vga_frame_fetch i_vga_frame_fetch (
		.clk(clk),
		.reset(reset),
		.start_dma(start_dma),
		.fb_base(fb_base),
		.credit_return(credit_return),
		.mem_read_data(mem_read_data),
		.mem_read_en(mem_read_en),
		.mem_read_addr(mem_read_addr),
		.push(push),
		.push_data(push_data),
		.flush(flush)
	);

	vga_pixel_fifo i_vga_pixel_fifo (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.push(push),
		.push_data(push_data),
		.pop(pop),
		.pop_data(pop_data),
		.empty(fifo_empty),
		.credit_return(credit_return)
	);

	// A visible pixel period consumes one pixel
	assign pixel_due = pixel_en && in_visible_region;

	// Underflow just shows black, nothing is popped
	assign pop = pixel_due && !fifo_empty;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			vga_de <= 1'b0;
			vga_color <= '0;
		end
		else
		begin
			// Both lag the visible flag by one clock
			vga_de <= in_visible_region;
			// Colour holds between strobes
			if (pixel_due)
				vga_color <= fifo_empty ? pixel_t'('0) : pop_data;
		end
	end

endmodule

// ==== rtl/vga_pixel_fifo.sv ====
`timescale 1ns/1ns

`include "vga_macros.svh"

module vga_pixel_fifo (
	input clk,
	input reset,
	input flush,
	input push,
	input vga_pkg::pixel_t push_data,
	input pop,
	output vga_pkg::pixel_t pop_data,
	output logic empty,
	output logic credit_return
);

	import vga_pkg::*;

	localparam PTR_WIDTH = $clog2(`VGA_FIFO_DEPTH);
	localparam COUNT_WIDTH = $clog2(`VGA_FIFO_DEPTH + 1);

	pixel_t storage[`VGA_FIFO_DEPTH];
	logic [PTR_WIDTH-1:0] read_ptr;
	logic [PTR_WIDTH-1:0] write_ptr;
	logic [COUNT_WIDTH-1:0] count;
	logic do_push;
	logic do_pop;

	// Circular increment, also correct for depths that are not a power of two
	function automatic logic [PTR_WIDTH-1:0] ptr_inc(input logic [PTR_WIDTH-1:0] ptr);
		if (ptr == PTR_WIDTH'(`VGA_FIFO_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign empty = count == '0;

	// Head entry is visible before the pop
	assign pop_data = storage[read_ptr];

	// Flush wins over both ports
	// Credits keep the writer from ever pushing into a full buffer
	assign do_push = push && !flush;
	assign do_pop = pop && !empty && !flush;

	// One credit back for each pixel that leaves
	assign credit_return = do_pop;

	always_ff @(posedge clk)
	begin
		if (do_push)
			storage[write_ptr] <= push_data;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			read_ptr <= '0;
			write_ptr <= '0;
			count <= '0;
		end
		else if (flush)
		begin
			// Empty in a single clock
			read_ptr <= '0;
			write_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				write_ptr <= ptr_inc(write_ptr);
			if (do_pop)
				read_ptr <= ptr_inc(read_ptr);
			count <= count + COUNT_WIDTH'(do_push) - COUNT_WIDTH'(do_pop);
		end
	end

endmodule

// ==== rtl/vga_frame_fetch.sv ====
`timescale 1ns/1ns

`include "vga_macros.svh"

module vga_frame_fetch (
	input clk,
	input reset,
	input start_dma,
	input [`VGA_MEM_ADDR_WIDTH-1:0] fb_base,
	input credit_return,
	input [`VGA_WORD_WIDTH-1:0] mem_read_data,
	output logic mem_read_en,
	output logic [`VGA_MEM_ADDR_WIDTH-1:0] mem_read_addr,
	output logic push,
	output vga_pkg::pixel_t push_data,
	output logic flush
);

	import vga_pkg::*;

	localparam CREDIT_WIDTH = $clog2(`VGA_FIFO_DEPTH + 1);

	logic start_dma_d;
	logic frame_start;
	logic active;
	logic read_pending;
	logic [CREDIT_WIDTH-1:0] credits;
	logic [`VGA_MEM_ADDR_WIDTH-1:0] read_addr;

	// Rising edge of the level request from the sequencer
	assign frame_start = start_dma && !start_dma_d;

	// One read per clock while credits remain
	// Nothing is issued before the first frame or around a flush
	assign mem_read_en = active && credits != '0 && !flush && !frame_start;
	assign mem_read_addr = read_addr;

	// Returned word lands one clock after the request
	// A read in flight at frame start is dropped
	assign push = read_pending && !frame_start;
	assign push_data = pixel_t'(mem_read_data[$bits(pixel_t)-1:0]);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			start_dma_d <= 1'b0;
			active <= 1'b0;
			read_pending <= 1'b0;
			flush <= 1'b0;
			credits <= CREDIT_WIDTH'(`VGA_FIFO_DEPTH);
			read_addr <= '0;
		end
		else
		begin
			start_dma_d <= start_dma;
			flush <= frame_start;

			if (frame_start)
			begin
				// Restart the frame from the base with an empty FIFO
				active <= 1'b1;
				read_pending <= 1'b0;
				credits <= CREDIT_WIDTH'(`VGA_FIFO_DEPTH);
				read_addr <= fb_base;
			end
			else
			begin
				read_pending <= mem_read_en;
				// Spend one credit per read, regain one per pop
				credits <= credits - CREDIT_WIDTH'(mem_read_en)
					+ CREDIT_WIDTH'(credit_return);
				if (mem_read_en)
					read_addr <= read_addr + 1'b1;
			end
		end
	end

endmodule

// ==== rtl/vga_sequencer.sv ====
`timescale 1ns/1ns

`include "vga_macros.svh"

module vga_sequencer (
	input clk,
	input reset,
	input sequencer_en,
	input prog_write_en,
	input [`VGA_WORD_WIDTH-1:0] prog_data,
	output logic vga_hs,
	output logic vga_vs,
	output logic in_visible_region,
	output logic start_dma,
	output logic pixel_en
);

	import vga_pkg::*;

	localparam PROG_ADDR_WIDTH = $clog2(`VGA_MAX_INSTRUCTIONS);

	typedef logic [PROG_ADDR_WIDTH-1:0] prog_addr_t;

	uop_t current_uop;
	counter_t counter[2];
	counter_t counter_nxt;
	prog_addr_t pc;
	prog_addr_t pc_nxt;
	prog_addr_t prog_load_addr;
	logic branch_en;

	// Microprogram store
	// Read address is the next pc so the word is ready at the strobe
	sram_1r1w #(
		.DATA_WIDTH($bits(uop_t)),
		.SIZE(`VGA_MAX_INSTRUCTIONS)
	) i_instruction_memory (
		.clk(clk),
		.read_en(1'b1),
		.read_addr(pc_nxt),
		.read_data(current_uop),
		.write_en(prog_write_en && !sequencer_en),
		.write_addr(prog_load_addr),
		.write_data(prog_data[$bits(uop_t)-1:0])
	);

	// INITCNT loads, LOOP counts down the selected counter
	assign counter_nxt = current_uop.instruction_type == INITCNT
		? current_uop.immediate_value
		: counter[current_uop.counter_select] - counter_t'(1);

	// Branch at end of frame or while the loop has iterations left
	assign branch_en = current_uop.frame_done
		|| (current_uop.instruction_type == LOOP && counter_nxt != '0);

	// Timing outputs straight from the current instruction
	assign vga_hs = current_uop.hsync && sequencer_en;
	assign vga_vs = current_uop.vsync && sequencer_en;
	assign in_visible_region = current_uop.in_visible_region && sequencer_en;

	// Level request for the whole first instruction of a frame
	assign start_dma = pc == '0 && sequencer_en;

	always_comb
	begin
		// Disabled sequencer parks on slot 0, ready for the next enable
		if (!sequencer_en)
			pc_nxt = '0;
		else if (pixel_en)
		begin
			if (branch_en)
				pc_nxt = prog_addr_t'(current_uop.immediate_value);
			else
				pc_nxt = pc + prog_addr_t'(1);
		end
		else
			pc_nxt = pc;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			pixel_en <= 1'b0;
			counter[0] <= '0;
			counter[1] <= '0;
			pc <= '0;
			prog_load_addr <= '0;
		end
		else
		begin
			// Pixel rate is half the clock
			pixel_en <= !pixel_en;
			pc <= pc_nxt;

			if (sequencer_en)
			begin
				// One instruction retires per pixel strobe
				if (pixel_en)
					counter[current_uop.counter_select] <= counter_nxt;

				// Next load session starts at slot 0
				prog_load_addr <= '0;
			end
			else if (prog_write_en)
				prog_load_addr <= prog_load_addr + prog_addr_t'(1);
		end
	end

endmodule

// ==== rtl/sram_1r1w.sv ====
`timescale 1ns/1ns

module sram_1r1w #(
	parameter DATA_WIDTH = 32,
	parameter SIZE = 64,
	localparam ADDR_WIDTH = $clog2(SIZE)
) (
	input clk,
	input read_en,
	input [ADDR_WIDTH-1:0] read_addr,
	output logic [DATA_WIDTH-1:0] read_data,
	input write_en,
	input [ADDR_WIDTH-1:0] write_addr,
	input [DATA_WIDTH-1:0] write_data
);

	logic [DATA_WIDTH-1:0] data[SIZE];

	// Synchronous write port
	always_ff @(posedge clk)
	begin
		if (write_en)
			data[write_addr] <= write_data;
	end

	// Registered read, one clock after the address
	always_ff @(posedge clk)
	begin
		if (read_en)
		begin
			// Same-cycle write to the read address forwards the new word
			if (write_en && write_addr == read_addr)
				read_data <= write_data;
			else
				read_data <= data[read_addr];
		end
	end

endmodule

// ==== rtl/vga_pkg.sv ====
package vga_pkg;

	// Microcode operations
	// INITCNT loads the selected counter with the immediate
	// LOOP decrements it and branches while the result is nonzero
	typedef enum logic {
		INITCNT,
		LOOP
	} instruction_type_t;

	// Loop counter, wide enough for a full line of pixel periods
	typedef logic [12:0] counter_t;

	// One microinstruction, taken from the low bits of a program word
	typedef struct packed {
		instruction_type_t instruction_type;
		logic counter_select;
		// Counter load value, and branch target for LOOP and frame_done
		counter_t immediate_value;
		logic vsync;
		logic hsync;
		logic frame_done;
		logic in_visible_region;
	} uop_t;

	// Frame-buffer pixel, low 24 bits of a memory word
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} pixel_t;

endpackage

// ==== rtl/vga_macros.svh ====
`ifndef VGA_MACROS_SVH
`define VGA_MACROS_SVH

// Microprogram slots in the timing sequencer
`define VGA_MAX_INSTRUCTIONS 48

// Pixel FIFO entries
// Also the number of credits the fetch unit starts a frame with
`define VGA_FIFO_DEPTH 8

// Frame-buffer word address width
`define VGA_MEM_ADDR_WIDTH 16

// Width of one program word and one memory word on the ports
`define VGA_WORD_WIDTH 32

`endif
